//--- bus/bus_interface.sv
`timescale 1ns/1ps

module bus_interface (
    input  logic                              sysclk,
    input  logic                              reset,
    input  logic [aq_pkg::bus_addr_width-1:0] bus_a,
    input  logic [aq_pkg::data_width-1:0]     bus_d_in,
    input  logic                              bus_rd_n,
    input  logic                              bus_wr_n,
    input  logic                              bus_mreq_n,
    input  logic                              bus_iorq_n,
    output logic [aq_pkg::data_width-1:0]     bus_d_out,
    output logic                              bus_d_oe,
    mem_if.host                               vram,
    mem_if.host                               sysram,
    io_if.bus                                 io
);

    localparam int unsigned sync_msb = aq_pkg::strobe_sync_depth - 1;

    logic [sync_msb:0]               wr_sync;
    logic [sync_msb:0]               rd_sync;
    logic [aq_pkg::data_width-1:0]   wrdata;
    logic                            bus_write;
    logic                            sel_vram;
    logic                            sel_sysram;

    ////////////////////
    // Strobes
    ////////////////////

    // Bit 0 is the newest sample
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_sync <= '1;
            rd_sync <= '1;
        end else begin
            wr_sync <= {wr_sync[sync_msb-1:0], bus_wr_n};
            rd_sync <= {rd_sync[sync_msb-1:0], bus_rd_n};
        end
    end

    // Data follows the bus for as long as the write strobe is low
    always_ff @(posedge sysclk) begin
        if (!bus_wr_n) begin
            wrdata <= bus_d_in;
        end
    end

    // Falling edge of the synced write strobe, dropped if a read overlaps
    assign bus_write = wr_sync[sync_msb] && !wr_sync[sync_msb-1] && rd_sync[sync_msb];

    ////////////////////
    // Memory decode
    ////////////////////
    assign sel_vram   = !bus_mreq_n && bus_a[15:11] == aq_pkg::vram_base_hi;
    assign sel_sysram = !bus_mreq_n && bus_a[15:11] == aq_pkg::sysram_base_hi;

    assign vram.addr     = bus_a[aq_pkg::ram_addr_width-1:0];
    assign vram.wrdata   = wrdata;
    assign vram.wren     = sel_vram && bus_write;

    assign sysram.addr   = bus_a[aq_pkg::ram_addr_width-1:0];
    assign sysram.wrdata = wrdata;
    assign sysram.wren   = sel_sysram && bus_write;

    // Port decode lives in io_regs
    assign io.iorq   = !bus_iorq_n;
    assign io.addr   = bus_a;
    assign io.wrdata = wrdata;
    assign io.write  = bus_write;

    ////////////////////
    // Read path
    ////////////////////
    always_comb begin
        if (sel_vram) begin
            bus_d_out = vram.rddata;
        end else if (sel_sysram) begin
            bus_d_out = sysram.rddata;
        end else begin
            bus_d_out = io.rddata;      // Zero unless io_regs decodes the port
        end
    end

    // Drive only while reading something that lives in the FPGA
    assign bus_d_oe = !bus_rd_n && (sel_vram || sel_sysram || io.hit);

endmodule

//--- bus/io_regs.sv
`timescale 1ns/1ps

module io_regs (
    input  logic                          sysclk,
    input  logic                          reset,
    input  logic                          cassette_in,
    input  logic                          printer_in,
    input  logic [aq_pkg::key_bits-1:0]   keys,        // Low means pressed
    output logic                          cassette_out,
    output logic                          printer_out,
    output logic                          cpm_remap,
    output logic [aq_pkg::data_width-1:0] scramble,
    io_if.regs                            io
);

    logic [7:0]                    port;
    logic                          sel_cassette;
    logic                          sel_cpm;
    logic                          sel_printer;
    logic                          sel_keyb;
    logic [aq_pkg::data_width-1:0] keyb_data;

    assign port = io.addr[7:0];

    assign sel_cassette = io.iorq && port == aq_pkg::io_cassette;
    assign sel_cpm      = io.iorq && port == aq_pkg::io_cpm;
    assign sel_printer  = io.iorq && port == aq_pkg::io_printer;
    assign sel_keyb     = io.iorq && port == aq_pkg::io_keyb_scramble;

    ////////////////////
    // Write registers
    ////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            cassette_out <= 1'b0;
            cpm_remap    <= 1'b0;
            printer_out  <= 1'b0;
            scramble     <= '0;
        end else if (io.write) begin
            if (sel_cassette) cassette_out <= io.wrdata[0];
            if (sel_cpm)      cpm_remap    <= io.wrdata[0];
            if (sel_printer)  printer_out  <= io.wrdata[0];
            if (sel_keyb)     scramble     <= io.wrdata;
        end
    end

    // Each low bit of A15-A8 selects one row, rows are ANDed
    always_comb begin
        keyb_data = '1;
        for (int i = 0; i < aq_pkg::key_bytes; i++) begin
            if (!io.addr[8 + i]) begin
                keyb_data &= keys[aq_pkg::data_width * i +: aq_pkg::data_width];
            end
        end
    end

    ////////////////////
    // Read side
    ////////////////////
    always_comb begin
        io.rddata = '0;
        if (sel_cassette) io.rddata = {7'b0, cassette_in};
        if (sel_printer)  io.rddata = {7'b0, printer_in};
        if (sel_keyb)     io.rddata = keyb_data;
    end

    assign io.hit = sel_cassette || sel_printer || sel_keyb;   // FDh is not readable

endmodule

//--- common/aq_pkg.sv
package aq_pkg;

    ////////////////////
    // Bus widths
    ////////////////////
    localparam int unsigned data_width     = 8;
    localparam int unsigned bus_addr_width = 16;

    ////////////////////
    // On-chip RAM
    ////////////////////
    localparam int unsigned ram_addr_width = 11;                  // 2 KB per RAM
    localparam int unsigned ram_depth      = 1 << ram_addr_width;

    // Upper five address bits of each RAM window
    localparam logic [4:0] vram_base_hi   = 5'b00110;             // 3000h-37FFh
    localparam logic [4:0] sysram_base_hi = 5'b00111;             // 3800h-3FFFh

    ////////////////////
    // I/O ports
    ////////////////////
    localparam logic [7:0] io_cassette      = 8'hFC;
    localparam logic [7:0] io_cpm           = 8'hFD;              // Write only
    localparam logic [7:0] io_printer       = 8'hFE;
    localparam logic [7:0] io_keyb_scramble = 8'hFF;              // Keys on read

    // Strobe and SPI pin synchronizer length
    localparam int unsigned strobe_sync_depth = 3;

    ////////////////////
    // Key matrix over SPI
    ////////////////////
    localparam logic [7:0]  spi_cmd_keys = 8'h10;
    localparam int unsigned key_bytes    = 8;                     // Matrix rows
    localparam int unsigned key_bits     = key_bytes * data_width;

    // Byte counter covers command, rows and an overrun
    localparam int unsigned spi_count_width = $clog2(key_bytes + 2);
    localparam logic [spi_count_width-1:0] spi_frame_bytes =
        spi_count_width'(key_bytes + 1);

endpackage

//--- common/io_if.sv
`timescale 1ns/1ps

interface io_if;

    logic                              iorq;     // I/O request level
    logic [aq_pkg::bus_addr_width-1:0] addr;     // Port in low byte, rows in high
    logic [aq_pkg::data_width-1:0]     wrdata;
    logic                              write;    // Single-cycle pulse
    logic [aq_pkg::data_width-1:0]     rddata;
    logic                              hit;      // Port is readable here

    modport bus (
        output iorq, addr, wrdata, write,
        input  rddata, hit
    );

    modport regs (
        input  iorq, addr, wrdata, write,
        output rddata, hit
    );

endinterface

//--- common/mem_if.sv
`timescale 1ns/1ps

interface mem_if;

    logic [aq_pkg::ram_addr_width-1:0] addr;
    logic [aq_pkg::data_width-1:0]     wrdata;
    logic                              wren;     // One sysclk per byte
    logic [aq_pkg::data_width-1:0]     rddata;   // Registered in the RAM

    modport host (
        output addr, wrdata, wren,
        input  rddata
    );

    modport ram (
        input  addr, wrdata, wren,
        output rddata
    );

endinterface

//--- dv/aq_checker.sv
`timescale 1ns/1ps

module aq_checker (
    input logic                          sysclk,
    input logic                          reset,
    input logic                          bus_rd_n,
    input logic                          bus_d_oe,
    input logic                          cassette_out,
    input logic                          printer_out,
    input logic                          cpm_remap,
    input logic [aq_pkg::data_width-1:0] scramble
);

    ////////////////////
    // Data bus enable
    ////////////////////
    oe_needs_read: assert property (@(posedge sysclk) bus_d_oe |-> !bus_rd_n)
        else $error("bus_d_oe high while bus_rd_n is high");

    oe_low_in_reset: assert property (@(posedge sysclk) reset |-> !bus_d_oe)
        else $error("bus_d_oe high during reset");

    // Registers clear once reset has been seen on a clock edge
    regs_clear_in_reset: assert property (@(posedge sysclk)
        reset && $past(reset) |->
            !cassette_out && !printer_out && !cpm_remap && scramble == '0)
        else $error("I/O register output not cleared during reset");

endmodule

bind aq_top aq_checker i_aq_checker (
    .sysclk       (sysclk),
    .reset        (reset),
    .bus_rd_n     (bus_rd_n),
    .bus_d_oe     (bus_d_oe),
    .cassette_out (cassette_out),
    .printer_out  (printer_out),
    .cpm_remap    (cpm_remap),
    .scramble     (scramble)
);

//--- dv/aq_patterns.txt
// Columns: op_addr_data_expect_test, hex. Ops: 1 mem write, 2 mem read, 3 I/O write, 4 I/O read,
// 5/6 mem/I/O read with no answer, 7 SPI frame (addr rows, data cmd), 8 stage row (addr row),
// 9 inputs (data bit0 cassette, bit1 printer), A outputs (data {oe,cpm,printer,cassette},
// expect scramble), B random RAM (data count), F end
A_0000_00_00_01
4_00FF_00_FF_01
1_3005_A5_00_02
1_3805_5A_00_02
2_3005_00_A5_02
2_3805_00_5A_02
1_37FF_C3_00_02
2_37FF_00_C3_02
B_0000_40_00_03
3_00FC_01_00_04
3_00FD_01_00_04
3_00FE_01_00_04
3_00FF_A5_00_04
A_0000_07_A5_04
3_00FC_FE_00_04
A_0000_06_A5_04
9_0000_01_00_05
4_00FC_00_01_05
4_00FE_00_00_05
9_0000_02_00_05
4_00FC_00_00_05
4_00FE_00_01_05
8_0000_FE_00_06
8_0001_FF_00_06
8_0002_5A_00_06
8_0003_FF_00_06
8_0004_EF_00_06
8_0005_FF_00_06
8_0006_FF_00_06
8_0007_3C_00_06
7_0008_10_00_06
4_FEFF_00_FE_06
4_FBFF_00_5A_06
4_7FFF_00_3C_06
4_6EFF_00_2C_06
4_00FF_00_08_06
4_FFFF_00_FF_06
8_0000_00_00_07
7_0008_20_00_07
4_00FF_00_08_07
7_0005_10_00_07
4_00FF_00_08_07
4_FEFF_00_FE_07
5_2FFF_00_00_08
5_4000_00_00_08
6_00FD_00_00_08
6_0012_00_00_08
1_40FC_01_00_08
3_0012_FF_00_08
A_0000_06_A5_08
F_0000_00_00_00

//--- dv/aq_tb.sv
`timescale 1ns/1ps

module aq_tb;

    localparam int max_patterns = 64;
    localparam int spi_half     = 8;      // sysclk cycles per SCLK half period
    localparam int wait_limit   = 16;

    logic        sysclk;
    logic        reset;
    logic [15:0] bus_a;
    logic [7:0]  bus_d_in;
    logic [7:0]  bus_d_out;
    logic        bus_d_oe;
    logic        bus_rd_n;
    logic        bus_wr_n;
    logic        bus_mreq_n;
    logic        bus_iorq_n;
    logic        cassette_in;
    logic        printer_in;
    logic        cassette_out;
    logic        printer_out;
    logic        cpm_remap;
    logic [7:0]  scramble;
    logic        esp_cs_n;
    logic        esp_sclk;
    logic        esp_mosi;

    logic [43:0] patterns [max_patterns];   // op, addr, data, expect, test
    logic [7:0]  rows [8];                  // Row bytes for the next SPI frame
    logic [7:0]  model [4096];              // Mirror of 3000h-3FFFh
    logic [31:0] lcg_state;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    logic [7:0]  cur_test;

    tb_clock #(.period_ns(100)) i_tb_clock (.sysclk(sysclk));

    aq_top i_aq_top (.*);

    function automatic string test_name(input logic [7:0] num);
        case (num)
            8'h01:   return "reset_state";
            8'h02:   return "ram_windows";
            8'h03:   return "ram_random";
            8'h04:   return "io_writes";
            8'h05:   return "io_reads";
            8'h06:   return "key_matrix";
            8'h07:   return "key_frames_ignored";
            8'h08:   return "unmapped";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_byte(input string label, input logic [7:0] expected,
                              input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s expected %02h actual %02h", label, expected, actual);
            test_errors++;
        end
    endtask

    task automatic idle_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge sysclk);
        end
    endtask

    task automatic wait_oe_low();
        int waited;
        waited = 0;
        while (bus_d_oe && waited < wait_limit) begin
            @(negedge sysclk);
            waited++;
        end
        if (bus_d_oe) begin
            $display("Timeout: bus_d_oe still driven %0d cycles after the strobe ended", waited);
            test_errors++;
        end
    endtask

    ////////////////////
    // Z80 bus cycle
    ////////////////////
    task automatic bus_cycle(input logic io, input logic write, input logic [15:0] addr,
                             input logic [7:0] data, output logic [7:0] rd_data,
                             output logic rd_oe);
        @(negedge sysclk);
        bus_a      = addr;
        bus_d_in   = data;
        bus_iorq_n = !io;
        bus_mreq_n = io;
        bus_wr_n   = !write;
        bus_rd_n   = write;
        for (int c = 1; c <= 5; c++) begin    // Strobe low for five cycles
            @(negedge sysclk);
            if (c == 4) begin
                rd_data = bus_d_out;
                rd_oe   = bus_d_oe;
            end
        end
        bus_rd_n   = 1'b1;
        bus_wr_n   = 1'b1;
        bus_mreq_n = 1'b1;
        bus_iorq_n = 1'b1;
        wait_oe_low();
        idle_cycles(2);
    endtask

    ////////////////////
    // SPI master
    ////////////////////
    task automatic spi_byte(input logic [7:0] value);
        logic [7:0] shift;
        shift = value;
        for (int b = 0; b < 8; b++) begin     // MSB first
            esp_mosi = shift[7];
            idle_cycles(spi_half);
            esp_sclk = 1'b1;
            idle_cycles(spi_half);
            esp_sclk = 1'b0;
            shift = {shift[6:0], 1'b0};
        end
    endtask

    task automatic spi_frame(input logic [7:0] cmd, input int count);
        @(negedge sysclk);
        esp_cs_n = 1'b0;
        idle_cycles(spi_half);
        spi_byte(cmd);
        for (int r = 0; r < count; r++) begin
            spi_byte(rows[3'(r)]);
        end
        idle_cycles(spi_half);
        esp_cs_n = 1'b1;
        idle_cycles(2 * spi_half);             // Commit passes the CS sync
    endtask

    task automatic random_ram(input int count);
        logic [11:0] offs [$];
        logic [11:0] off;
        logic [7:0]  data;
        logic [7:0]  rd;
        logic        oe;
        for (int i = 0; i < count; i++) begin
            lcg_state = lcg_next(lcg_state);
            off       = lcg_state[27:16];
            lcg_state = lcg_next(lcg_state);
            data      = lcg_state[23:16];
            bus_cycle(1'b0, 1'b1, {4'h3, off}, data, rd, oe);
            model[off] = data;
            offs.push_back(off);
        end
        foreach (offs[i]) begin
            bus_cycle(1'b0, 1'b0, {4'h3, offs[i]}, 8'h00, rd, oe);
            check_byte($sformatf("%s oe at 3%03h", test_name(cur_test), offs[i]),
                       8'h01, {7'b0, oe});
            check_byte($sformatf("%s at 3%03h", test_name(cur_test), offs[i]),
                       model[offs[i]], rd);
        end
    endtask

    task automatic run_record(input logic [43:0] rec);
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  expect_val;
        logic [7:0]  rd;
        logic        oe;
        string       label;
        addr       = rec[39:24];
        data       = rec[23:16];
        expect_val = rec[15:8];
        label      = $sformatf("%s at %04h", test_name(cur_test), addr);
        case (rec[43:40])
            4'h1: bus_cycle(1'b0, 1'b1, addr, data, rd, oe);
            4'h3: bus_cycle(1'b1, 1'b1, addr, data, rd, oe);
            4'h2, 4'h4: begin
                bus_cycle(rec[42], 1'b0, addr, 8'h00, rd, oe);   // Op 4 is I/O
                check_byte({label, " oe"}, 8'h01, {7'b0, oe});
                check_byte(label, expect_val, rd);
            end
            4'h5, 4'h6: begin                 // Nothing in the FPGA answers
                bus_cycle(rec[41], 1'b0, addr, 8'h00, rd, oe);
                check_byte({label, " oe"}, 8'h00, {7'b0, oe});
            end
            4'h7: spi_frame(data, int'(addr));
            4'h8: rows[addr[2:0]] = data;
            4'h9: begin
                @(negedge sysclk);
                cassette_in = data[0];
                printer_in  = data[1];
            end
            4'hA: begin
                @(negedge sysclk);
                check_byte({label, " flags"}, {4'h0, data[3:0]},
                           {4'h0, bus_d_oe, cpm_remap, printer_out, cassette_out});
                check_byte({label, " scramble"}, expect_val, scramble);
            end
            4'hB: random_ram(int'(data));
            default: begin
                $display("Unknown operation %h in the pattern table", rec[43:40]);
                test_errors++;
            end
        endcase
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s: ok", test_name(cur_test));
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name(cur_test), test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        logic [43:0] rec;
        int          idx;
        logic        done;
        logic        started;
        reset       = 1'b1;
        bus_a       = '0;
        bus_d_in    = '0;
        bus_rd_n    = 1'b1;
        bus_wr_n    = 1'b1;
        bus_mreq_n  = 1'b1;
        bus_iorq_n  = 1'b1;
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        esp_cs_n    = 1'b1;
        esp_sclk    = 1'b0;
        esp_mosi    = 1'b0;
        lcg_state   = 32'd25216;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        cur_test     = '0;
        foreach (patterns[i]) patterns[i] = '0;
        foreach (rows[i]) rows[i] = 8'hFF;
        $readmemh("dv/aq_patterns.txt", patterns);

        idle_cycles(3);
        reset = 1'b0;
        idle_cycles(2);

        idx     = 0;
        done    = 1'b0;
        started = 1'b0;
        while (!done && idx < max_patterns) begin
            rec = patterns[idx];
            if (rec[43:40] == 4'hF || rec[43:40] == 4'h0) begin
                done = 1'b1;
            end else begin
                if (!started || rec[7:0] != cur_test) begin   // Next test begins
                    if (started) finish_test();
                    cur_test = rec[7:0];
                    started  = 1'b1;
                end
                run_record(rec);
                idx++;
            end
        end
        if (started) finish_test();
        if (!started || !done) begin
            $display("Pattern table is empty or has no end marker");
            tests_failed++;
        end

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 100
) (
    output logic sysclk
);

    initial begin
        sysclk = 1'b0;
    end

    // Half period per toggle
    always begin
        #(period_ns / 2) sysclk = ~sysclk;
    end

endmodule

//--- files.f
common/aq_pkg.sv
common/mem_if.sv
common/io_if.sv
source/byte_ram.sv
bus/bus_interface.sv
bus/io_regs.sv
source/spi_keys.sv
source/aq_top.sv
dv/tb_clock.sv
dv/aq_checker.sv
dv/aq_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Mdir "$build_dir" --top-module aq_tb -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$build_dir/Vaq_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$log_file"; then
    exit 1
fi
exit 0

//--- source/aq_top.sv
`timescale 1ns/1ps

module aq_top (
    input  logic                              sysclk,
    input  logic                              reset,

    // Z80 bus, data split for simulation
    input  logic [aq_pkg::bus_addr_width-1:0] bus_a,
    input  logic [aq_pkg::data_width-1:0]     bus_d_in,
    output logic [aq_pkg::data_width-1:0]     bus_d_out,
    output logic                              bus_d_oe,
    input  logic                              bus_rd_n,
    input  logic                              bus_wr_n,
    input  logic                              bus_mreq_n,
    input  logic                              bus_iorq_n,

    // Cassette and printer pins
    input  logic                              cassette_in,
    output logic                              cassette_out,
    input  logic                              printer_in,
    output logic                              printer_out,

    // Remap and scramble registers
    output logic                              cpm_remap,
    output logic [aq_pkg::data_width-1:0]     scramble,

    // Host SPI
    input  logic                              esp_cs_n,
    input  logic                              esp_sclk,
    input  logic                              esp_mosi
);

    logic [aq_pkg::key_bits-1:0] keys;

    mem_if vram_mem ();
    mem_if sysram_mem ();
    io_if  io_bus ();

    ////////////////////
    // Bus side
    ////////////////////
    bus_interface i_bus_interface (
        .sysclk     (sysclk),
        .reset      (reset),
        .bus_a      (bus_a),
        .bus_d_in   (bus_d_in),
        .bus_rd_n   (bus_rd_n),
        .bus_wr_n   (bus_wr_n),
        .bus_mreq_n (bus_mreq_n),
        .bus_iorq_n (bus_iorq_n),
        .bus_d_out  (bus_d_out),
        .bus_d_oe   (bus_d_oe),
        .vram       (vram_mem.host),
        .sysram     (sysram_mem.host),
        .io         (io_bus.bus)
    );

    byte_ram vram (
        .sysclk (sysclk),
        .port   (vram_mem.ram)
    );

    byte_ram sysram (
        .sysclk (sysclk),
        .port   (sysram_mem.ram)
    );

    io_regs i_io_regs (
        .sysclk       (sysclk),
        .reset        (reset),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .keys         (keys),
        .cassette_out (cassette_out),
        .printer_out  (printer_out),
        .cpm_remap    (cpm_remap),
        .scramble     (scramble),
        .io           (io_bus.regs)
    );

    ////////////////////
    // Key matrix
    ////////////////////
    spi_keys i_spi_keys (
        .sysclk   (sysclk),
        .reset    (reset),
        .esp_cs_n (esp_cs_n),
        .esp_sclk (esp_sclk),
        .esp_mosi (esp_mosi),
        .keys     (keys)
    );

endmodule

//--- source/byte_ram.sv
`timescale 1ns/1ps

module byte_ram (
    input  logic sysclk,
    mem_if.ram   port
);

    logic [aq_pkg::data_width-1:0] mem [aq_pkg::ram_depth];

    // Write on the strobe pulse, read every cycle
    always_ff @(posedge sysclk) begin
        if (port.wren) begin
            mem[port.addr] <= port.wrdata;
        end
        port.rddata <= mem[port.addr];   // Old data on a same-cycle write
    end

endmodule

//--- source/spi_keys.sv
`timescale 1ns/1ps

module spi_keys (
    input  logic                        sysclk,
    input  logic                        reset,
    input  logic                        esp_cs_n,
    input  logic                        esp_sclk,
    input  logic                        esp_mosi,
    output logic [aq_pkg::key_bits-1:0] keys
);

    localparam int unsigned sync_msb = aq_pkg::strobe_sync_depth - 1;

    logic [sync_msb:0]                     cs_sync;
    logic [sync_msb:0]                     sclk_sync;
    logic [sync_msb:0]                     mosi_sync;
    logic                                  cs_idle;
    logic                                  cs_rise;
    logic                                  sclk_rise;
    logic [2:0]                            bit_cnt;
    logic [aq_pkg::spi_count_width-1:0]    byte_cnt;
    logic                                  cmd_ok;
    logic                                  byte_done;
    logic [6:0]                            shift_reg;
    logic [aq_pkg::data_width-1:0]         rx_byte;
    logic [aq_pkg::key_bits-1:0]           staged;

    ////////////////////
    // Pin sync
    ////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            cs_sync   <= '1;
            sclk_sync <= '0;
            mosi_sync <= '0;
        end else begin
            cs_sync   <= {cs_sync[sync_msb-1:0], esp_cs_n};
            sclk_sync <= {sclk_sync[sync_msb-1:0], esp_sclk};
            mosi_sync <= {mosi_sync[sync_msb-1:0], esp_mosi};
        end
    end

    assign cs_idle   = cs_sync[sync_msb];
    assign cs_rise   = cs_sync[sync_msb-1] && !cs_sync[sync_msb];
    assign sclk_rise = sclk_sync[sync_msb-1] && !sclk_sync[sync_msb];

    // MSB first, last bit taken straight from the sync
    assign rx_byte   = {shift_reg, mosi_sync[sync_msb]};
    assign byte_done = sclk_rise && !cs_idle && bit_cnt == 3'd7;

    ////////////////////
    // Frame control
    ////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            cmd_ok   <= 1'b0;
            keys     <= '1;                          // Nothing pressed
        end else begin
            if (cs_idle) begin                       // Abort or end of frame
                bit_cnt  <= '0;
                byte_cnt <= '0;
                cmd_ok   <= 1'b0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (byte_done && byte_cnt != '1) begin   // Saturates on long frames
                    byte_cnt <= byte_cnt + aq_pkg::spi_count_width'(1);
                end
                if (byte_done && byte_cnt == '0) begin
                    cmd_ok <= rx_byte == aq_pkg::spi_cmd_keys;
                end
            end
            // Commit only a complete key frame
            if (cs_rise && cmd_ok && byte_cnt == aq_pkg::spi_frame_bytes) begin
                keys <= staged;
            end
        end
    end

    // Rows shift down so the first data byte ends up as row 0
    always_ff @(posedge sysclk) begin
        if (sclk_rise) begin
            shift_reg <= rx_byte[6:0];
        end
        if (byte_done && cmd_ok && byte_cnt != '0) begin
            staged <= {rx_byte, staged[aq_pkg::key_bits-1:aq_pkg::data_width]};
        end
    end

endmodule
